// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath word, also the instruction width
`define CPU_WORD_WIDTH 32

// architectural register count, register 0 reads as zero
`define CPU_REG_COUNT 32

// data memory depth in words, addressed by byte address bits above bit 1
`define CPU_DMEM_WORDS 256

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== design/cpu_types_pkg.sv ====
`include "cpu_config.svh"

package cpu_types_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;  // data or instruction word
    typedef logic [4:0] regbits_t;               // register index

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDI  = 6'h08,
        ADDIU = 6'h09,
        SLTI  = 6'h0a,
        SLTIU = 6'h0b,
        ANDI  = 6'h0c,
        ORI   = 6'h0d,
        XORI  = 6'h0e,
        LUI   = 6'h0f,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f  // not part of MIPS32, stops the core
    } opcode_t;

    // function field of R-type instructions, instr[5:0]
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        JR   = 6'h08,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a,
        SLTU = 6'h2b
    } funct_t;

    // operations the ALU understands
    typedef enum logic [3:0] {
        ALU_SLL  = 4'd0,
        ALU_SRL  = 4'd1,
        ALU_ADD  = 4'd2,
        ALU_SUB  = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } aluop_t;

endpackage

// ==== design/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  cpu_types_pkg::word_t  instr,
    output logic                  alusrc,
    output logic                  shift,
    output logic                  lui,
    output logic                  ext,
    output logic                  regdst,
    output logic                  regwr,
    output logic                  memwr,
    output logic                  memread,
    output logic                  memtoreg,
    output logic                  branch,
    output logic                  bne,
    output logic                  jump,
    output logic                  jumpal,
    output logic                  jumpreg,
    output logic                  halt,
    output cpu_types_pkg::aluop_t aluop
);

    import cpu_types_pkg::*;

    opcode_t opcode;
    funct_t  func;

    assign opcode = opcode_t'(instr[31:26]);
    assign func   = funct_t'(instr[5:0]);

    always_comb
    begin
        alusrc   = 1'b0;
        shift    = 1'b0;
        lui      = 1'b0;
        ext      = 1'b1;     // sign extension unless the opcode says otherwise
        regdst   = 1'b0;
        regwr    = 1'b0;     // unknown opcodes leave the register file alone
        memwr    = 1'b0;
        memread  = 1'b0;
        memtoreg = 1'b0;
        branch   = 1'b0;
        bne      = 1'b0;
        jump     = 1'b0;
        jumpal   = 1'b0;
        jumpreg  = 1'b0;
        halt     = 1'b0;
        aluop    = ALU_ADD;

        case (opcode)
            RTYPE:
            begin
                regdst = 1'b1;
                regwr  = 1'b1;
                case (func)
                    ADD, ADDU: aluop = ALU_ADD;  // no overflow trap
                    SUB, SUBU: aluop = ALU_SUB;
                    AND:       aluop = ALU_AND;
                    OR:        aluop = ALU_OR;
                    XOR:       aluop = ALU_XOR;
                    NOR:       aluop = ALU_NOR;
                    SLT:       aluop = ALU_SLT;
                    SLTU:      aluop = ALU_SLTU;
                    SLL:
                    begin
                        shift = 1'b1;
                        aluop = ALU_SLL;
                    end
                    SRL:
                    begin
                        shift = 1'b1;
                        aluop = ALU_SRL;
                    end
                    JR:
                    begin
                        jumpreg = 1'b1;
                        regwr   = 1'b0;  // jr has no destination
                    end
                    default:   regwr = 1'b0;
                endcase
            end
            ADDI, ADDIU:
            begin
                alusrc = 1'b1;
                regwr  = 1'b1;
                ext    = (opcode == ADDIU);  // addi keeps the zero-extended immediate
            end
            ANDI, ORI, XORI:
            begin
                alusrc = 1'b1;
                regwr  = 1'b1;
                ext    = 1'b0;
                aluop  = (opcode == ANDI) ? ALU_AND : (opcode == ORI) ? ALU_OR : ALU_XOR;
            end
            SLTI, SLTIU:
            begin
                alusrc = 1'b1;
                regwr  = 1'b1;
                aluop  = (opcode == SLTI) ? ALU_SLT : ALU_SLTU;
            end
            LUI:
            begin
                lui    = 1'b1;
                alusrc = 1'b1;
                regwr  = 1'b1;
                ext    = 1'b0;
                aluop  = ALU_OR;  // upper immediate ored with a zero operand
            end
            LW:
            begin
                alusrc   = 1'b1;
                regwr    = 1'b1;
                memread  = 1'b1;
                memtoreg = 1'b1;
            end
            SW:
            begin
                alusrc = 1'b1;
                memwr  = 1'b1;
            end
            BEQ, BNE:
            begin
                branch = (opcode == BEQ);
                bne    = (opcode == BNE);
                aluop  = ALU_SUB;  // zero flag compares rs and rt
            end
            J:   jump = 1'b1;
            JAL:
            begin
                jump   = 1'b1;
                jumpal = 1'b1;
                regwr  = 1'b1;  // link register
            end
            HALT: halt = 1'b1;
            default: ;
        endcase
    end

    // a store never writes back, whatever the opcode table grows into
    always_comb
    begin
        assert final (!(memwr && regwr))
            else $error("control_unit: memwr and regwr both set for %h", instr);
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_types_pkg::word_t  porta,
    input  cpu_types_pkg::word_t  portb,
    input  logic [4:0]            shamt,
    input  cpu_types_pkg::aluop_t aluop,
    output cpu_types_pkg::word_t  result,
    output logic                  zero
);

    import cpu_types_pkg::*;

    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt   = $signed(porta) < $signed(portb);
    assign unsigned_lt = porta < portb;

    always_comb
    begin
        case (aluop)
            ALU_SLL:  result = porta << shamt;   // porta carries rt on shifts
            ALU_SRL:  result = porta >> shamt;   // logical, zeros shifted in
            ALU_ADD:  result = porta + portb;
            ALU_SUB:  result = porta - portb;
            ALU_AND:  result = porta & portb;
            ALU_OR:   result = porta | portb;
            ALU_XOR:  result = porta ^ portb;
            ALU_NOR:  result = ~(porta | portb);
            ALU_SLT:  result = word_t'(signed_lt);
            ALU_SLTU: result = word_t'(unsigned_lt);
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);  // branches rely on this after ALU_SUB

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   wen,
    input  cpu_types_pkg::regbits_t wsel,
    input  cpu_types_pkg::regbits_t rsel1,
    input  cpu_types_pkg::regbits_t rsel2,
    input  cpu_types_pkg::word_t   wdat,
    output cpu_types_pkg::word_t   rdat1,
    output cpu_types_pkg::word_t   rdat2
);

    import cpu_types_pkg::*;

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wen && (wsel != '0))  // register 0 is hardwired
        begin
            regs[wsel] <= wdat;
        end
    end

    assign rdat1 = regs[rsel1];  // asynchronous read, same-cycle operands
    assign rdat2 = regs[rsel2];

    // an attempted write to register 0 leaves it zero at the next edge
    assert property (@(posedge CLK) disable iff (!rst_n)
        (wen && (wsel == '0)) |=> (regs[0] == '0))
        else $error("register_file: register 0 changed");

endmodule

// ==== design/data_memory.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module data_memory #(
    parameter int DEPTH = `CPU_DMEM_WORDS
) (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 wen,
    input  cpu_types_pkg::word_t addr,
    input  cpu_types_pkg::word_t wdat,
    output cpu_types_pkg::word_t rdat
);

    import cpu_types_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t          mem [DEPTH];
    logic [AW-1:0]  idx;

    assign idx = AW'((addr >> 2) % DEPTH);  // byte address to word index, wraps at DEPTH

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (wen)
        begin
            mem[idx] <= wdat;
        end
    end

    assign rdat = mem[idx];

    // only whole words are stored, byte lanes do not exist here
    assert property (@(posedge CLK) disable iff (!rst_n) wen |-> (addr[1:0] == 2'b00))
        else $error("data_memory: unaligned store to %h", addr);

endmodule

// ==== design/single_cycle_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module single_cycle_cpu (
    input  logic                    CLK,
    input  logic                    rst_n,
    output cpu_types_pkg::word_t    imem_addr,
    input  cpu_types_pkg::word_t    imem_data,
    output logic                    wb_en,
    output cpu_types_pkg::regbits_t wb_reg,
    output cpu_types_pkg::word_t    wb_data,
    output logic                    halted
);

    import cpu_types_pkg::*;

    word_t    pc;
    word_t    pc_plus4;
    word_t    next_pc;
    word_t    ext_imm;
    word_t    branch_off;
    word_t    jump_target;
    word_t    rdat1;
    word_t    rdat2;
    word_t    porta;
    word_t    portb;
    word_t    alu_result;
    word_t    dmem_rdat;
    word_t    wdat;
    regbits_t wsel;
    logic     zero;
    logic     take_branch;

    logic     alusrc, shift, lui, ext, regdst, regwr, memwr, memread, memtoreg;
    logic     branch, bne, jump, jumpal, jumpreg, halt;
    aluop_t   aluop;

    control_unit control_unit_i (
        .instr    (imem_data),
        .alusrc   (alusrc),
        .shift    (shift),
        .lui      (lui),
        .ext      (ext),
        .regdst   (regdst),
        .regwr    (regwr),
        .memwr    (memwr),
        .memread  (memread),
        .memtoreg (memtoreg),
        .branch   (branch),
        .bne      (bne),
        .jump     (jump),
        .jumpal   (jumpal),
        .jumpreg  (jumpreg),
        .halt     (halt),
        .aluop    (aluop)
    );

    // immediate extension, the branch offset is always signed
    assign ext_imm    = ext ? {{16{imem_data[15]}}, imem_data[15:0]} : {16'h0, imem_data[15:0]};
    assign branch_off = {{14{imem_data[15]}}, imem_data[15:0], 2'b00};

    // shifts take rt on porta, lui ors its immediate with zero
    assign porta = lui ? '0 : (shift ? rdat2 : rdat1);
    assign portb = alusrc ? (lui ? {imem_data[15:0], 16'h0} : ext_imm) : rdat2;

    alu alu_i (
        .porta  (porta),
        .portb  (portb),
        .shamt  (imem_data[10:6]),
        .aluop  (aluop),
        .result (alu_result),
        .zero   (zero)
    );

    register_file register_file_i (
        .CLK   (CLK),
        .rst_n (rst_n),
        .wen   (wb_en),
        .wsel  (wsel),
        .rsel1 (imem_data[25:21]),
        .rsel2 (imem_data[20:16]),
        .wdat  (wdat),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    data_memory data_memory_i (
        .CLK   (CLK),
        .rst_n (rst_n),
        .wen   (memwr && !halted),
        .addr  (alu_result),
        .wdat  (rdat2),
        .rdat  (dmem_rdat)
    );

    // destination is rt for I-type, rd for R-type, ra for jal
    assign wsel = jumpal ? 5'd31 : (regdst ? imem_data[15:11] : imem_data[20:16]);
    assign wdat = memtoreg ? dmem_rdat : (jumpal ? pc_plus4 : alu_result);

    assign wb_en   = regwr && !halted;
    assign wb_reg  = wsel;
    assign wb_data = wdat;

    assign pc_plus4    = pc + 32'd4;
    assign jump_target = {pc_plus4[31:28], imem_data[25:0], 2'b00};
    assign take_branch = (branch && zero) || (bne && !zero);

    always_comb
    begin
        if (halt || halted)
            next_pc = pc;  // halt parks the fetch address
        else if (jumpreg)
            next_pc = rdat1;
        else if (jump)
            next_pc = jump_target;
        else if (take_branch)
            next_pc = pc_plus4 + branch_off;
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc     <= `CPU_RESET_PC;
            halted <= 1'b0;
        end
        else
        begin
            pc <= next_pc;
            if (halt)
                halted <= 1'b1;  // sticky until reset
        end
    end

    assign imem_addr = pc;

    // the address the ALU forms for a load must land on a word
    assert property (@(posedge CLK) disable iff (!rst_n)
        (memread && !halted) |-> (alu_result[1:0] == 2'b00))
        else $error("single_cycle_cpu: unaligned load at pc %h", pc);

endmodule

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

    // the opcodes and function codes follow MIPS32 except for halt
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_HALT  = 6'h3f;
    localparam logic [5:0] F_SLL    = 6'h00;
    localparam logic [5:0] F_SRL    = 6'h02;
    localparam logic [5:0] F_JR     = 6'h08;
    localparam logic [5:0] F_ADD    = 6'h20;
    localparam logic [5:0] F_ADDU   = 6'h21;
    localparam logic [5:0] F_SUB    = 6'h22;
    localparam logic [5:0] F_SUBU   = 6'h23;
    localparam logic [5:0] F_AND    = 6'h24;
    localparam logic [5:0] F_OR     = 6'h25;
    localparam logic [5:0] F_XOR    = 6'h26;
    localparam logic [5:0] F_NOR    = 6'h27;
    localparam logic [5:0] F_SLT    = 6'h2a;
    localparam logic [5:0] F_SLTU   = 6'h2b;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;    // address at which the instruction is fetched
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        halt;  // halted as seen while the entry is presented
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        halted;

    entry_t      tbl [$];
    logic [31:0] shadow [32];  // register values the program should have produced
    logic [31:0] exp_pc;
    logic        exp_halt;
    integer      seed;
    int          errors;
    int          cycles;
    int          limit;

    single_cycle_cpu single_cycle_cpu_i (
        .CLK       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sh);
        rtype_word = {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        itype_word = {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        sext16 = {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] zext16(input logic [15:0] v);
        zext16 = {16'h0000, v};
    endfunction

    // records one entry at the expected PC and advances the model unless halted
    task automatic add_entry(input logic [31:0] instr, input logic en, input logic [4:0] rd,
                             input logic [31:0] data);
        entry_t e;
        e.instr = instr;
        e.pc    = exp_pc;
        e.en    = en && !exp_halt;
        e.rd    = rd;
        e.data  = data;
        e.halt  = exp_halt;
        tbl.push_back(e);
        if (e.en && (rd != 5'd0))
            shadow[rd] = data;
        if (!exp_halt)
            exp_pc = exp_pc + 32'd4;
    endtask

    task automatic add_branch(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                              input logic [15:0] off);
        logic        taken;
        logic [31:0] dest;
        taken = (op == OP_BEQ) ? (shadow[rs] == shadow[rt]) : (shadow[rs] != shadow[rt]);
        dest  = exp_pc + 32'd4 + (sext16(off) << 2);
        add_entry(itype_word(op, rs, rt, off), 1'b0, 5'd0, 32'h0);
        if (taken)
            exp_pc = dest;
    endtask

    task automatic add_jump(input logic [5:0] op, input logic [25:0] tgt);
        logic [31:0] pc4;
        logic [31:0] dest;
        pc4  = exp_pc + 32'd4;
        dest = {pc4[31:28], tgt, 2'b00};
        add_entry({op, tgt}, op == OP_JAL, 5'd31, pc4);  // jal links pc+4 into r31
        exp_pc = dest;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r1v;
        logic [31:0] ret;
        logic [31:0] hold;
        logic [15:0] imm;
        logic [4:0]  sh;
        a = $random(seed);
        b = $random(seed);
        r = $random(seed);
        imm = r[15:0];
        r = $random(seed);
        sh = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
        a[31] = 1'b1;    // a negative and b positive, so slt and sltu disagree
        b[31] = 1'b0;
        a[15] = 1'b0;    // r1 stays positive so slti and sltiu disagree on the negative immediate
        imm[15] = 1'b1;  // zero and sign extension give different operands
        r1v = sext16(a[15:0]);

        add_entry(itype_word(OP_ADDIU, 5'd0, 5'd1, a[15:0]), 1'b1, 5'd1, r1v);
        add_entry(itype_word(OP_LUI, 5'd0, 5'd2, a[31:16]), 1'b1, 5'd2, {a[31:16], 16'h0});
        add_entry(itype_word(OP_ORI, 5'd2, 5'd2, a[15:0]), 1'b1, 5'd2, a);
        add_entry(itype_word(OP_LUI, 5'd0, 5'd3, b[31:16]), 1'b1, 5'd3, {b[31:16], 16'h0});
        add_entry(itype_word(OP_ORI, 5'd3, 5'd3, b[15:0]), 1'b1, 5'd3, b);

        add_entry(rtype_word(F_ADD, 5'd2, 5'd3, 5'd4, 5'd0), 1'b1, 5'd4, a + b);
        add_entry(rtype_word(F_ADDU, 5'd2, 5'd3, 5'd5, 5'd0), 1'b1, 5'd5, a + b);
        add_entry(rtype_word(F_SUB, 5'd2, 5'd3, 5'd6, 5'd0), 1'b1, 5'd6, a - b);
        add_entry(rtype_word(F_SUBU, 5'd3, 5'd2, 5'd7, 5'd0), 1'b1, 5'd7, b - a);
        add_entry(rtype_word(F_AND, 5'd2, 5'd3, 5'd8, 5'd0), 1'b1, 5'd8, a & b);
        add_entry(rtype_word(F_OR, 5'd2, 5'd3, 5'd9, 5'd0), 1'b1, 5'd9, a | b);
        add_entry(rtype_word(F_XOR, 5'd2, 5'd3, 5'd10, 5'd0), 1'b1, 5'd10, a ^ b);
        add_entry(rtype_word(F_NOR, 5'd2, 5'd3, 5'd11, 5'd0), 1'b1, 5'd11, ~(a | b));
        add_entry(rtype_word(F_SLT, 5'd2, 5'd3, 5'd12, 5'd0), 1'b1, 5'd12,
                  ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        add_entry(rtype_word(F_SLTU, 5'd2, 5'd3, 5'd13, 5'd0), 1'b1, 5'd13,
                  (a < b) ? 32'd1 : 32'd0);
        add_entry(rtype_word(F_SLT, 5'd3, 5'd2, 5'd14, 5'd0), 1'b1, 5'd14,
                  ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        add_entry(rtype_word(F_SLTU, 5'd3, 5'd2, 5'd15, 5'd0), 1'b1, 5'd15,
                  (b < a) ? 32'd1 : 32'd0);

        // addi and the logic immediates are zero-extended on this core
        add_entry(itype_word(OP_ADDI, 5'd3, 5'd16, imm), 1'b1, 5'd16, b + zext16(imm));
        add_entry(itype_word(OP_ADDIU, 5'd3, 5'd17, imm), 1'b1, 5'd17, b + sext16(imm));
        add_entry(itype_word(OP_ANDI, 5'd2, 5'd18, imm), 1'b1, 5'd18, a & zext16(imm));
        add_entry(itype_word(OP_ORI, 5'd2, 5'd19, imm), 1'b1, 5'd19, a | zext16(imm));
        add_entry(itype_word(OP_XORI, 5'd2, 5'd20, imm), 1'b1, 5'd20, a ^ zext16(imm));
        add_entry(itype_word(OP_SLTI, 5'd1, 5'd21, imm), 1'b1, 5'd21,
                  ($signed(r1v) < $signed(sext16(imm))) ? 32'd1 : 32'd0);
        add_entry(itype_word(OP_SLTIU, 5'd1, 5'd22, imm), 1'b1, 5'd22,
                  (r1v < sext16(imm)) ? 32'd1 : 32'd0);

        add_entry(rtype_word(F_SLL, 5'd0, 5'd2, 5'd23, sh), 1'b1, 5'd23, a << sh);
        add_entry(rtype_word(F_SRL, 5'd0, 5'd2, 5'd24, sh), 1'b1, 5'd24, a >> sh);
        add_entry(rtype_word(F_SLL, 5'd0, 5'd3, 5'd0, sh), 1'b1, 5'd0, b << sh);
        add_entry(rtype_word(F_ADDU, 5'd0, 5'd0, 5'd25, 5'd0), 1'b1, 5'd25, 32'h0);

        add_entry(itype_word(OP_ADDIU, 5'd0, 5'd26, 16'h0040), 1'b1, 5'd26, 32'h40);
        add_entry(itype_word(OP_SW, 5'd26, 5'd2, 16'h0000), 1'b0, 5'd0, 32'h0);
        add_entry(itype_word(OP_SW, 5'd26, 5'd3, 16'h0004), 1'b0, 5'd0, 32'h0);
        add_entry(itype_word(OP_LW, 5'd26, 5'd27, 16'h0000), 1'b1, 5'd27, a);
        add_entry(itype_word(OP_LW, 5'd26, 5'd28, 16'h0004), 1'b1, 5'd28, b);
        add_entry(itype_word(OP_LW, 5'd26, 5'd29, 16'h0008), 1'b1, 5'd29, 32'h0);

        add_branch(OP_BEQ, 5'd2, 5'd2, 16'h0002);
        add_branch(OP_BEQ, 5'd2, 5'd3, 16'h0002);
        add_branch(OP_BNE, 5'd2, 5'd3, 16'hfffd);  // a backward branch checks the offset sign
        add_branch(OP_BNE, 5'd3, 5'd3, 16'h0005);

        add_jump(OP_J, 26'h0000040);
        add_jump(OP_JAL, 26'h0000080);
        ret = shadow[31];
        add_entry(rtype_word(F_JR, 5'd31, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0);
        exp_pc = ret;
        add_entry(rtype_word(F_ADDU, 5'd31, 5'd0, 5'd30, 5'd0), 1'b1, 5'd30, ret);

        hold = exp_pc;
        add_entry({OP_HALT, 26'h0}, 1'b0, 5'd0, 32'h0);
        exp_pc = hold;
        exp_halt = 1'b1;
        add_entry(itype_word(OP_ADDIU, 5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h1234);
        add_entry(itype_word(OP_SW, 5'd26, 5'd1, 16'h0000), 1'b0, 5'd0, 32'h0);
        add_entry(itype_word(OP_LW, 5'd26, 5'd27, 16'h0000), 1'b1, 5'd27, a);
        add_entry(rtype_word(F_ADDU, 5'd2, 5'd3, 5'd4, 5'd0), 1'b1, 5'd4, a + b);
    endtask

    task automatic check_entry(input int i);
        entry_t e;
        e = tbl[i];
        if (imem_addr !== e.pc)
        begin
            $display("MISMATCH at %0t: entry %0d imem_addr %h, expected %h",
                     $time, i, imem_addr, e.pc);
            errors++;
        end
        if (halted !== e.halt)
        begin
            $display("MISMATCH at %0t: entry %0d halted %b, expected %b",
                     $time, i, halted, e.halt);
            errors++;
        end
        if (wb_en !== e.en)
        begin
            $display("MISMATCH at %0t: entry %0d wb_en %b, expected %b", $time, i, wb_en, e.en);
            errors++;
        end
        if (e.en && (wb_reg !== e.rd))
        begin
            $display("MISMATCH at %0t: entry %0d wb_reg %0d, expected %0d",
                     $time, i, wb_reg, e.rd);
            errors++;
        end
        if (e.en && (wb_data !== e.data))
        begin
            $display("MISMATCH at %0t: entry %0d wb_data %h, expected %h",
                     $time, i, wb_data, e.data);
            errors++;
        end
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("timeout: the table did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        imem_data = 32'h0;
        errors    = 0;
        cycles    = 0;
        seed      = 94;
        exp_pc    = `CPU_RESET_PC;
        exp_halt  = 1'b0;
        for (int i = 0; i < 32; i++)
        begin
            shadow[i] = 32'h0;
        end
        build_program();
        limit = 2 * tbl.size() + 50;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;  // the first entry goes out on the same edge
        foreach (tbl[i])
        begin
            imem_data <= tbl[i].instr;
            @(negedge clk);
            check_entry(i);
            @(posedge clk);
        end

        $display("errors: %0d over %0d table entries", errors, tbl.size());
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
design/cpu_types_pkg.sv
design/control_unit.sv
design/alu.sv
design/register_file.sv
design/data_memory.sv
design/single_cycle_cpu.sv
tests/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the single-cycle CPU testbench with Verilator and runs it into sim.log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f \
    --top-module cpu_tb \
    --Mdir obj_dir \
    -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"
